// File: rtl/frontend_pkg.sv
package frontend_pkg;

  // machine widths
  localparam int XLEN      = 64;
  localparam int PC_W      = XLEN;
  localparam int INST_W    = 32;
  localparam int REG_W     = 5;   // architectural register index

  // superscalar width and fetch buffer depth
  localparam int NUM_SUPER = 2;
  localparam int NUM_FB    = 8;   // must stay a power of two for pointer wrap
  localparam int FB_IDX_W  = $clog2(NUM_FB);

  // instruction memory
  localparam int IMEM_WORDS = 16;
  localparam int IMEM_AW    = $clog2(IMEM_WORDS);

  // opcodes that carry rs2 instead of an immediate
  localparam logic [6:0] OPC_OP   = 7'b0110011;
  localparam logic [6:0] OPC_OP32 = 7'b0111011;

  typedef struct packed {
    logic [PC_W-1:0]   npc;   // address of the following word
    logic [INST_W-1:0] inst;
    logic              valid;
  } fb_entry_t;

  // one instruction word, read either as R-type or as I-type
  typedef union packed {
    struct packed {
      logic [6:0]       funct7;
      logic [REG_W-1:0] rs2;
      logic [REG_W-1:0] rs1;
      logic [2:0]       funct3;
      logic [REG_W-1:0] rd;
      logic [6:0]       opcode;
    } r;
    struct packed {
      logic [11:0]      imm12;
      logic [REG_W-1:0] rs1;
      logic [2:0]       funct3;
      logic [REG_W-1:0] rd;
      logic [6:0]       opcode;
    } i;
  } inst_word_u;

endpackage

// File: rtl/fetch_bundle_if.sv
`timescale 1ns/1ns

interface fetch_bundle_if import frontend_pkg::*; ();

  logic [NUM_SUPER-1:0][PC_W-1:0]   npc;   // per slot, own address plus 4
  logic [NUM_SUPER-1:0][INST_W-1:0] inst;
  logic [NUM_SUPER-1:0]             valid;
  logic                             fetch_en;  // buffer can take this pair

  modport fetch (
    output npc,
    output inst,
    output valid,
    input  fetch_en
  );

  // buffer side of the pair
  modport buffer (
    input  npc,
    input  inst,
    input  valid,
    output fetch_en
  );

endinterface

// File: rtl/inst_rom.sv
`timescale 1ns/1ns

module inst_rom import frontend_pkg::*; (
  input  logic [IMEM_AW-1:0] addr0,
  input  logic [IMEM_AW-1:0] addr1,
  output logic [INST_W-1:0]  data0,
  output logic [INST_W-1:0]  data1
);

  logic [INST_W-1:0] mem [IMEM_WORDS];

  // words past the end of the program image read as zero
  initial begin
    for (int w = 0; w < IMEM_WORDS; w++) begin
      mem[w] = '0;
    end
    $readmemh("program.hex", mem);
  end

  // two independent read ports, no latency
  assign data0 = mem[addr0];
  assign data1 = mem[addr1];

endmodule

// File: rtl/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage import frontend_pkg::*; (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               en,
  input  logic               rollback,
  input  logic [PC_W-1:0]    rollback_pc,
  output logic [IMEM_AW-1:0] rom_addr0,
  output logic [IMEM_AW-1:0] rom_addr1,
  input  logic [INST_W-1:0]  rom_data0,
  input  logic [INST_W-1:0]  rom_data1,
  fetch_bundle_if.fetch      bus
);

  logic [PC_W-1:0]   pc;
  logic [PC_W-1:0]   pc_step;
  logic [PC_W-3:0]   word0;      // word index of slot 0
  logic [PC_W-3:0]   word1;
  logic              odd_word;
  logic              in_rom0;
  logic              in_rom1;
  logic [NUM_SUPER-1:0] slot_valid;

  assign word0    = pc[PC_W-1:2];
  assign word1    = word0 + 1'b1;
  assign odd_word = pc[2];

  assign rom_addr0 = word0[IMEM_AW-1:0];
  assign rom_addr1 = word1[IMEM_AW-1:0];

  // bounds check on the full index, the rom address alone would alias
  assign in_rom0 = (word0 < IMEM_WORDS);
  assign in_rom1 = (word1 < IMEM_WORDS);

  // odd word address fetches one word so the next pair lands even
  assign slot_valid[0] = in_rom0;
  assign slot_valid[1] = in_rom1 & ~odd_word;

  assign bus.valid   = slot_valid;
  assign bus.inst[0] = rom_data0;
  assign bus.inst[1] = rom_data1;
  assign bus.npc[0]  = pc + PC_W'(4);
  assign bus.npc[1]  = pc + PC_W'(8);

  // 4 bytes per word handed over
  always_comb begin
    case (slot_valid)
      2'b11:        pc_step = PC_W'(8);
      2'b01, 2'b10: pc_step = PC_W'(4);
      default:      pc_step = '0;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (rollback) begin
      pc <= rollback_pc;  // redirect wins over any pending pair
    end else if (en & bus.fetch_en) begin
      pc <= pc + pc_step;
    end
  end

endmodule

// File: rtl/fetch_buffer.sv
`timescale 1ns/1ns

module fetch_buffer import frontend_pkg::*; (
  input  logic                             clock,
  input  logic                             rst_n,
  input  logic                             en,
  input  logic                             rollback,
  input  logic                             get_next_inst,
  fetch_bundle_if.buffer                   bus,
  output logic [NUM_SUPER-1:0][PC_W-1:0]   out_npc,
  output logic [NUM_SUPER-1:0][INST_W-1:0] out_inst,
  output logic                             dispatch_valid
);

  fb_entry_t [NUM_FB-1:0] fb;
  fb_entry_t [NUM_FB-1:0] fb_next;

  logic [FB_IDX_W-1:0] head;      // next free entry
  logic [FB_IDX_W-1:0] tail;      // oldest entry
  logic [FB_IDX_W-1:0] head_p1;
  logic [FB_IDX_W-1:0] head_p2;
  logic [FB_IDX_W-1:0] tail_p1;
  logic [FB_IDX_W-1:0] tail_p2;
  logic [FB_IDX_W-1:0] head_next;
  logic [FB_IDX_W-1:0] tail_next;
  logic                one_slot;  // pair carries a single word
  logic                two_slot;
  logic                hi_only;   // the single word sits in slot 1

  // pointers wrap naturally at NUM_FB
  assign head_p1 = head + FB_IDX_W'(1);
  assign head_p2 = head + FB_IDX_W'(2);
  assign tail_p1 = tail + FB_IDX_W'(1);
  assign tail_p2 = tail + FB_IDX_W'(2);

  assign one_slot = (bus.valid == 2'b01) | (bus.valid == 2'b10);
  assign two_slot = (bus.valid == 2'b11);
  assign hi_only  = ~bus.valid[0];

  // room for every word the pair brings, never during a redirect
  assign bus.fetch_en = ((one_slot & ~fb[head].valid) |
                         (two_slot & ~fb[head].valid & ~fb[head_p1].valid)) & ~rollback;

  assign dispatch_valid = fb[tail].valid & fb[tail_p1].valid;

  assign out_npc[0]  = fb[tail].npc;
  assign out_npc[1]  = fb[tail_p1].npc;
  assign out_inst[0] = fb[tail].inst;
  assign out_inst[1] = fb[tail_p1].inst;

  assign head_next = (one_slot & bus.fetch_en) ? head_p1 :
                     (two_slot & bus.fetch_en) ? head_p2 : head;
  assign tail_next = get_next_inst ? tail_p2 : tail;

  always_comb begin
    fb_next = fb;
    if (one_slot & bus.fetch_en) begin
      fb_next[head].npc   = hi_only ? bus.npc[1] : bus.npc[0];
      fb_next[head].inst  = hi_only ? bus.inst[1] : bus.inst[0];
      fb_next[head].valid = 1'b1;
    end else if (two_slot & bus.fetch_en) begin
      fb_next[head]    = '{npc: bus.npc[0], inst: bus.inst[0], valid: 1'b1};
      fb_next[head_p1] = '{npc: bus.npc[1], inst: bus.inst[1], valid: 1'b1};
    end
    // release the oldest pair, never overlaps the entries just written
    if (get_next_inst) begin
      fb_next[tail].valid    = 1'b0;
      fb_next[tail_p1].valid = 1'b0;
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      head <= '0;
      tail <= '0;
      for (int e = 0; e < NUM_FB; e++) begin
        fb[e].valid <= 1'b0;
      end
    end else if (rollback) begin
      head <= '0;  // flush, payload left as is
      tail <= '0;
      for (int e = 0; e < NUM_FB; e++) begin
        fb[e].valid <= 1'b0;
      end
    end else if (en) begin
      fb   <= fb_next;
      head <= head_next;
      tail <= tail_next;
    end
  end

endmodule

// File: rtl/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder import frontend_pkg::*; (
  input  logic [NUM_SUPER-1:0][PC_W-1:0]   in_npc,
  input  logic [NUM_SUPER-1:0][INST_W-1:0] in_inst,
  input  logic                             in_valid,   // whole pair ready
  output logic [NUM_SUPER-1:0][PC_W-1:0]   dec_npc,
  output logic [NUM_SUPER-1:0][INST_W-1:0] dec_inst,
  output logic [NUM_SUPER-1:0][REG_W-1:0]  dec_rd,
  output logic [NUM_SUPER-1:0][REG_W-1:0]  dec_rs1,
  output logic [NUM_SUPER-1:0][REG_W-1:0]  dec_rs2,
  output logic [NUM_SUPER-1:0][XLEN-1:0]   dec_imm,
  output logic [NUM_SUPER-1:0]             dec_rtype
);

  inst_word_u [NUM_SUPER-1:0] word;
  logic       [NUM_SUPER-1:0] is_rtype;

  assign word     = in_inst;
  assign dec_npc  = in_npc;
  assign dec_inst = in_inst;

  always_comb begin
    for (int s = 0; s < NUM_SUPER; s++) begin
      is_rtype[s] = (word[s].r.opcode == OPC_OP) | (word[s].r.opcode == OPC_OP32);
    end
  end

  // decoded fields read as zero while the pair is not valid
  always_comb begin
    for (int s = 0; s < NUM_SUPER; s++) begin
      dec_rtype[s] = in_valid & is_rtype[s];
      dec_rd[s]    = in_valid ? word[s].r.rd : '0;
      dec_rs1[s]   = in_valid ? word[s].i.rs1 : '0;  // same bits in both views
      if (!in_valid) begin
        dec_rs2[s] = '0;
        dec_imm[s] = '0;
      end else if (is_rtype[s]) begin
        dec_rs2[s] = word[s].r.rs2;
        dec_imm[s] = '0;
      end else begin
        dec_rs2[s] = '0;
        dec_imm[s] = {{(XLEN-12){word[s].i.imm12[11]}}, word[s].i.imm12};
      end
    end
  end

endmodule

// File: rtl/frontend_top.sv
`timescale 1ns/1ns

module frontend_top import frontend_pkg::*; (
  input  logic                             clock,
  input  logic                             rst_n,
  input  logic                             en,
  input  logic                             rollback,
  input  logic [PC_W-1:0]                  rollback_pc,
  input  logic                             get_next_inst,
  output logic                             dispatch_valid,
  output logic [NUM_SUPER-1:0][PC_W-1:0]   dec_npc,
  output logic [NUM_SUPER-1:0][INST_W-1:0] dec_inst,
  output logic [NUM_SUPER-1:0][REG_W-1:0]  dec_rd,
  output logic [NUM_SUPER-1:0][REG_W-1:0]  dec_rs1,
  output logic [NUM_SUPER-1:0][REG_W-1:0]  dec_rs2,
  output logic [NUM_SUPER-1:0][XLEN-1:0]   dec_imm,
  output logic [NUM_SUPER-1:0]             dec_rtype
);

  logic [IMEM_AW-1:0]               rom_addr0;
  logic [IMEM_AW-1:0]               rom_addr1;
  logic [INST_W-1:0]                rom_data0;
  logic [INST_W-1:0]                rom_data1;
  logic [NUM_SUPER-1:0][PC_W-1:0]   fb_npc;    // oldest pair in the buffer
  logic [NUM_SUPER-1:0][INST_W-1:0] fb_inst;

  fetch_bundle_if fetch_bus ();

  inst_rom inst_rom_inst (
    .addr0 (rom_addr0),
    .addr1 (rom_addr1),
    .data0 (rom_data0),
    .data1 (rom_data1)
  );

  fetch_stage fetch_stage_inst (
    .clock       (clock),
    .rst_n       (rst_n),
    .en          (en),
    .rollback    (rollback),
    .rollback_pc (rollback_pc),
    .rom_addr0   (rom_addr0),
    .rom_addr1   (rom_addr1),
    .rom_data0   (rom_data0),
    .rom_data1   (rom_data1),
    .bus         (fetch_bus.fetch)
  );

  fetch_buffer fetch_buffer_inst (
    .clock          (clock),
    .rst_n          (rst_n),
    .en             (en),
    .rollback       (rollback),
    .get_next_inst  (get_next_inst),
    .bus            (fetch_bus.buffer),
    .out_npc        (fb_npc),
    .out_inst       (fb_inst),
    .dispatch_valid (dispatch_valid)
  );

  inst_decoder inst_decoder_inst (
    .in_npc    (fb_npc),
    .in_inst   (fb_inst),
    .in_valid  (dispatch_valid),
    .dec_npc   (dec_npc),
    .dec_inst  (dec_inst),
    .dec_rd    (dec_rd),
    .dec_rs1   (dec_rs1),
    .dec_rs2   (dec_rs2),
    .dec_imm   (dec_imm),
    .dec_rtype (dec_rtype)
  );

endmodule

// File: sim/frontend_sva.sv
`timescale 1ns/1ns

module frontend_sva import frontend_pkg::*; (
  input logic                   clock,
  input logic                   rst_n,
  input logic                   en,
  input logic                   rollback,
  input logic                   get_next_inst,
  input logic                   dispatch_valid,
  input logic [FB_IDX_W-1:0]    tail,
  input fb_entry_t [NUM_FB-1:0] fb
);

  logic [NUM_FB-1:0] entry_valid;

  always_comb begin
    for (int e = 0; e < NUM_FB; e++) begin
      entry_valid[e] = fb[e].valid;
    end
  end

  // no pair taken on the redirect edge and nothing older survives it
  rollback_flushes_buffer: assert property (
    @(posedge clock) disable iff (!rst_n) rollback |=> (entry_valid == '0)
  ) else $error("buffer entry still valid in the cycle after rollback");

  release_needs_pair: assert property (
    @(posedge clock) disable iff (!rst_n) get_next_inst |-> dispatch_valid
  ) else $error("get_next_inst raised without dispatch_valid");

  // oldest entry holds until released or flushed
  tail_entry_holds: assert property (
    @(posedge clock) disable iff (!rst_n)
      (fb[tail].valid && !(en && get_next_inst) && !rollback) |=> fb[tail].valid
  ) else $error("tail entry lost before it was consumed");

endmodule

bind fetch_buffer frontend_sva frontend_sva_inst (
  .clock          (clock),
  .rst_n          (rst_n),
  .en             (en),
  .rollback       (rollback),
  .get_next_inst  (get_next_inst),
  .dispatch_valid (dispatch_valid),
  .tail           (tail),
  .fb             (fb)
);

// File: sim/frontend_tb.sv
`timescale 1ns/1ns

module frontend_tb import frontend_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int PAIRS      = IMEM_WORDS / 2;
  localparam int MAX_GAP    = 12;
  localparam int PAIR_LIMIT = 8;  // cycles a pair may take to show up
  localparam int RUN_CYCLES = 5 * PAIRS * (PAIR_LIMIT + 3) + PAIRS * (MAX_GAP + 3) + 100;

  logic                             clock;
  logic                             rst_n;
  logic                             en;
  logic                             rollback;
  logic [PC_W-1:0]                  rollback_pc;
  logic                             get_next_inst;
  logic                             dispatch_valid;
  logic [NUM_SUPER-1:0][PC_W-1:0]   dec_npc;
  logic [NUM_SUPER-1:0][INST_W-1:0] dec_inst;
  logic [NUM_SUPER-1:0][REG_W-1:0]  dec_rd;
  logic [NUM_SUPER-1:0][REG_W-1:0]  dec_rs1;
  logic [NUM_SUPER-1:0][REG_W-1:0]  dec_rs2;
  logic [NUM_SUPER-1:0][XLEN-1:0]   dec_imm;
  logic [NUM_SUPER-1:0]             dec_rtype;

  logic [INST_W-1:0] rom_img [IMEM_WORDS];  // reference copy of program.hex
  integer seed = 32'hec5b_afe8;
  int     exp_idx;        // word expected in slot 0 of the next pair
  bit     check_fields;
  int     checks;
  int     errors;
  int     errors_at_start;
  int     tests_run;
  int     tests_failed;
  string  test_name;

  frontend_top frontend_top_inst (.*);

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  function automatic bit word_is_rtype(logic [INST_W-1:0] w);
    return (w[6:0] == 7'h33) || (w[6:0] == 7'h3b);
  endfunction

  function automatic logic [63:0] expected_imm(logic [INST_W-1:0] w);
    if (word_is_rtype(w)) return 64'd0;
    return {{52{w[31]}}, w[31:20]};  // I-type imm12, sign-extended
  endfunction

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("mismatch at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  task automatic require(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("error at %0t ns: %s", $time, what);
    end
  endtask

  task automatic verify_slot(input int s, input int idx);
    logic [INST_W-1:0] w;
    if (idx >= IMEM_WORDS) begin
      require(1'b0, $sformatf("slot %0d holds word %0d past the end of the rom", s, idx));
    end else begin
      w = rom_img[idx];
      compare_value($sformatf("dec_npc[%0d]", s), 64'(idx * 4 + 4), dec_npc[s]);
      compare_value($sformatf("dec_inst[%0d]", s), 64'(w), dec_inst[s]);
      if (check_fields) begin
        compare_value($sformatf("dec_rd[%0d]", s), 64'(w[11:7]), dec_rd[s]);
        compare_value($sformatf("dec_rs1[%0d]", s), 64'(w[19:15]), dec_rs1[s]);
        compare_value($sformatf("dec_rs2[%0d]", s),
                      word_is_rtype(w) ? 64'(w[24:20]) : 64'd0, dec_rs2[s]);
        compare_value($sformatf("dec_imm[%0d]", s), expected_imm(w), dec_imm[s]);
        compare_value($sformatf("dec_rtype[%0d]", s), 64'(word_is_rtype(w)), dec_rtype[s]);
      end
    end
  endtask

  // one cycle of observation, outputs read at the falling edge
  task automatic watch_pair(input bit take, output bit took);
    took = 1'b0;
    @(negedge clock);
    if (dispatch_valid) begin
      verify_slot(0, exp_idx);
      verify_slot(1, exp_idx + 1);
      if (take) begin
        @(posedge clock);
        get_next_inst <= 1'b1;
        @(posedge clock);
        get_next_inst <= 1'b0;
        exp_idx += 2;
        took = 1'b1;
      end
    end
  endtask

  task automatic consume_pairs(input int count, input int max_gap);
    int gap;
    int waited;
    bit took;
    for (int p = 0; p < count; p++) begin
      gap = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
      repeat (gap) watch_pair(1'b0, took);
      took = 1'b0;
      waited = 0;
      while (!took && waited < PAIR_LIMIT) begin
        watch_pair(1'b1, took);
        waited++;
      end
      require(took, $sformatf("no pair offered for word %0d", exp_idx));
    end
  endtask

  task automatic apply_reset();
    @(posedge clock);
    rst_n         <= 1'b0;
    en            <= 1'b1;
    rollback      <= 1'b0;
    get_next_inst <= 1'b0;
    repeat (2) @(posedge clock);
    rst_n <= 1'b1;
    exp_idx = 0;
  endtask

  task automatic wait_first_pair(input string after);
    int cycles;
    cycles = 0;
    while (!dispatch_valid && cycles < 4) begin
      @(negedge clock);
      cycles++;
    end
    require(dispatch_valid, $sformatf("no pair within 4 cycles after %s", after));
  endtask

  task automatic redirect(input logic [PC_W-1:0] target);
    @(posedge clock);
    rollback    <= 1'b1;
    rollback_pc <= target;
    @(posedge clock);
    rollback <= 1'b0;
    exp_idx = int'(target >> 2);
    @(negedge clock);
    require(!dispatch_valid, "buffer still offers a pair after rollback");
  endtask

  task automatic open_test(input string name);
    test_name       = name;
    errors_at_start = errors;
    tests_run++;
  endtask

  task automatic close_test();
    if (errors == errors_at_start) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  task automatic stream_order();
    open_test("stream order");
    check_fields = 1'b0;
    apply_reset();
    wait_first_pair("reset");
    consume_pairs(PAIRS, 0);
    close_test();
  endtask

  task automatic decode_fields();
    open_test("decode fields");
    check_fields = 1'b1;
    apply_reset();
    wait_first_pair("reset");
    consume_pairs(PAIRS, 0);
    close_test();
  endtask

  task automatic backpressure();
    bit took;
    open_test("back-pressure");
    check_fields = 1'b1;
    apply_reset();
    repeat (MAX_GAP) watch_pair(1'b0, took);  // pair must stay put meanwhile
    require(!frontend_top_inst.fetch_bus.fetch_en, "fetch_en stayed high with the buffer full");
    consume_pairs(PAIRS, MAX_GAP);
    close_test();
  endtask

  task automatic enable_freeze();
    bit took;
    open_test("enable low freeze");
    check_fields = 1'b1;
    apply_reset();
    wait_first_pair("reset");
    consume_pairs(1, 0);
    @(posedge clock);
    en <= 1'b0;
    @(negedge clock);
    require(dispatch_valid, "no pair waiting when en fell");
    @(posedge clock);
    get_next_inst <= 1'b1;  // a release request that must be ignored
    repeat (6) begin
      watch_pair(1'b0, took);
      compare_value("dispatch_valid", 64'd1, 64'(dispatch_valid));
    end
    @(posedge clock);
    get_next_inst <= 1'b0;
    @(posedge clock);
    en <= 1'b1;
    consume_pairs(PAIRS - 1, 0);
    close_test();
  endtask

  task automatic rollback_odd();
    open_test("rollback to odd word");
    check_fields = 1'b1;
    apply_reset();
    wait_first_pair("reset");
    consume_pairs(2, 0);
    repeat (3) @(posedge clock);  // buffer runs ahead of dispatch
    redirect(PC_W'(20));
    wait_first_pair("rollback");
    consume_pairs(2, 0);
    close_test();
  endtask

  // continues the stream left by rollback_odd
  task automatic rom_end();
    bit took;
    open_test("end of rom");
    check_fields = 1'b0;
    consume_pairs((IMEM_WORDS - exp_idx) / 2, 0);
    repeat (12) begin
      watch_pair(1'b0, took);
      compare_value("dispatch_valid", 64'd0, 64'(dispatch_valid));
    end
    close_test();
  endtask

  initial begin
    rst_n         = 1'b0;
    en            = 1'b1;
    rollback      = 1'b0;
    rollback_pc   = '0;
    get_next_inst = 1'b0;
    for (int w = 0; w < IMEM_WORDS; w++) begin
      rom_img[w] = '0;
    end
    $readmemh("program.hex", rom_img);
    stream_order();
    decode_fields();
    backpressure();
    enable_freeze();
    rollback_odd();
    rom_end();
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run did not complete", RUN_CYCLES);
    $display("tests failed");
    $finish;
  end

endmodule

// File: files.f
rtl/frontend_pkg.sv
rtl/fetch_bundle_if.sv
rtl/inst_rom.sv
rtl/fetch_stage.sv
rtl/fetch_buffer.sv
rtl/inst_decoder.sv
rtl/frontend_top.sv
sim/frontend_sva.sv
sim/frontend_tb.sv

// File: run.sh
#!/bin/sh
# run from the project root so program.hex is found
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module frontend_tb \
  -f files.f -o frontend_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/frontend_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

grep -qx "all tests passed" sim.log && exit 0 || exit 1

// File: program.hex
// one 32-bit instruction word per line, hex, starting at word address 0
// R-type (opcodes 33 and 3b) mixed with I-type, words 14 and 15 stay zero
003100B3
FFF00293
40128333
005303BB
01013403
7FF48493
00C5C533
80057593
4020863B
FF06069B
0056E733
FFC72783
02E78833
000800E7
